/* src/mdu_pkg.sv */
/*
  Shared types of the multiply/divide unit.
  Word width is fixed at 32; no block is built for any other width.
  A 64-bit result is {HI, LO}: remainder:quotient or product high:low.
*/
package mdu_pkg;

  // machine word width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [2*XLEN-1:0] dword_t;

  // opcodes accepted from the CPU
  typedef enum logic [2:0] {
    MULT  = 3'd0,
    MULTU = 3'd1,
    DIV   = 3'd2,
    DIVU  = 3'd3,
    MTHI  = 3'd4,
    MTLO  = 3'd5
  } mdu_op_e;

  // command sampled with cmd_valid
  typedef struct packed {
    mdu_op_e op;
    word_t   a;
    word_t   b;
  } mdu_cmd_t;

  // one HI/LO write, request or granted
  typedef struct packed {
    logic  we_hi;
    logic  we_lo;
    word_t hi;
    word_t lo;
  } hilo_wr_t;

  // engine busy levels
  typedef struct packed {
    logic mul;
    logic div;
  } mdu_busy_t;

endpackage

/* src/mdu_issue.sv */
/*
  Command decode for the multiply/divide unit.
  Starts, move-to requests and cmd_err come out one cycle after cmd_valid.
  A command aimed at a busy engine is dropped, not queued.
*/
`timescale 1ns/100ps

module mdu_issue (
  input  logic               clk,
  input  logic               nrst,
  input  logic               cmd_valid,
  input  mdu_pkg::mdu_cmd_t  cmd,
  input  mdu_pkg::mdu_busy_t busy,
  output logic               div_start,
  output logic               mul_start,
  output mdu_pkg::word_t     opa,
  output mdu_pkg::word_t     opb,
  output logic               signd,
  output mdu_pkg::hilo_wr_t  mt_req,
  output logic               cmd_err
);
  import mdu_pkg::*;

  logic is_div;
  logic is_mul;
  logic is_mthi;
  logic is_mtlo;
  logic is_signed;
  logic refuse;
  logic mt_hi_q;
  logic mt_lo_q;

  // opcode decode
  always_comb
  begin
    is_div    = 1'b0;
    is_mul    = 1'b0;
    is_mthi   = 1'b0;
    is_mtlo   = 1'b0;
    is_signed = 1'b0;
    case (cmd.op)
      MULT:
      begin
        is_mul    = 1'b1;
        is_signed = 1'b1;
      end
      MULTU: is_mul = 1'b1;
      DIV:
      begin
        is_div    = 1'b1;
        is_signed = 1'b1;
      end
      DIVU:  is_div = 1'b1;
      MTHI:  is_mthi = 1'b1;
      MTLO:  is_mtlo = 1'b1;
      default: ;
    endcase
  end

  // engine still working on an earlier command
  assign refuse = cmd_valid && ((is_div && busy.div) || (is_mul && busy.mul));

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      div_start <= 1'b0;
      mul_start <= 1'b0;
      mt_hi_q   <= 1'b0;
      mt_lo_q   <= 1'b0;
      cmd_err   <= 1'b0;
    end
    else
    begin
      div_start <= cmd_valid && is_div && !busy.div;
      mul_start <= cmd_valid && is_mul && !busy.mul;
      mt_hi_q   <= cmd_valid && is_mthi;
      mt_lo_q   <= cmd_valid && is_mtlo;
      cmd_err   <= refuse;
    end
  end

  // operands travel with the start pulse
  always_ff @(posedge clk)
  begin
    if (cmd_valid)
    begin
      opa   <= cmd.a;
      opb   <= cmd.b;
      signd <= is_signed;
    end
  end

  // move-to value is operand a, for either half
  assign mt_req = '{we_hi: mt_hi_q, we_lo: mt_lo_q, hi: opa, lo: opa};

endmodule

/* src/long_idiv.sv */
/*
  Restoring divider, one quotient bit per cycle.
  Operands are sampled only while start is high.
  Zero divisor or zero dividend gives remainder 0 and quotient 0.
  Signed: quotient truncates toward zero, remainder has the dividend sign.
  Result is held as a request until granted.
*/
`timescale 1ns/100ps

module long_idiv (
  input  logic              clk,
  input  logic              nrst,
  input  logic              start,
  input  mdu_pkg::word_t    dividend,
  input  mdu_pkg::word_t    divider,
  input  logic              signd,
  input  logic              grant,
  output mdu_pkg::hilo_wr_t req,
  output logic              busy
);
  import mdu_pkg::*;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

  div_state_e state;
  logic [4:0] cnt;
  dword_t     qr;
  word_t      abs_divider;
  logic       neg_quot;
  logic       neg_rem;
  word_t      abs_a;
  word_t      abs_b;
  logic       zero_op;
  dword_t     rq_src;
  word_t      dv_src;
  logic [XLEN:0] diff;
  dword_t     step_qr;
  word_t      rem;
  word_t      quot;

  assign abs_a   = (signd && dividend[XLEN-1]) ? -dividend : dividend;
  assign abs_b   = (signd && divider[XLEN-1]) ? -divider : divider;
  assign zero_op = (dividend == '0) || (divider == '0);

  // first step is taken in the start cycle straight from the inputs
  assign rq_src = start ? {{XLEN{1'b0}}, abs_a} : qr;
  assign dv_src = start ? abs_b : abs_divider;

  // trial subtract on the working remainder plus next dividend bit
  assign diff = rq_src[2*XLEN-1:XLEN-1] - {1'b0, dv_src};

  // borrow means restore, shift in 0; else keep difference, shift in 1
  assign step_qr = diff[XLEN] ? {rq_src[2*XLEN-2:0], 1'b0}
                              : {diff[XLEN-1:0], rq_src[XLEN-2:0], 1'b1};

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      state <= DIV_IDLE;
      cnt   <= '0;
    end
    else if (start)
    begin
      // 31 steps left after the one in the start cycle
      state <= zero_op ? DIV_DONE : DIV_RUN;
      cnt   <= 5'd31;
    end
    else
    begin
      case (state)
        DIV_RUN:
        begin
          cnt <= cnt - 5'd1;
          if (cnt == 5'd1)
            state <= DIV_DONE;
        end
        DIV_DONE:
          if (grant)
            state <= DIV_IDLE;
        default: ;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      qr          <= zero_op ? '0 : step_qr;
      abs_divider <= abs_b;
      neg_quot    <= signd && (dividend[XLEN-1] ^ divider[XLEN-1]);
      neg_rem     <= signd && dividend[XLEN-1];
    end
    else if (state == DIV_RUN)
      qr <= step_qr;
  end

  assign rem  = qr[2*XLEN-1:XLEN];
  assign quot = qr[XLEN-1:0];

  // remainder in HI, quotient in LO, sign restored
  assign req.we_hi = (state == DIV_DONE);
  assign req.we_lo = (state == DIV_DONE);
  assign req.hi    = neg_rem ? -rem : rem;
  assign req.lo    = neg_quot ? -quot : quot;

  // covers the start cycle too
  assign busy = start || (state != DIV_IDLE);

endmodule

/* src/long_imul.sv */
/*
  Shift-add multiplier on absolute values, sign fixed at the end.
  Two multiplier bits are consumed in the start cycle, one per cycle after.
  Operands are sampled only while start is high.
  Product is held as a request until granted.
*/
`timescale 1ns/100ps

module long_imul (
  input  logic              clk,
  input  logic              nrst,
  input  logic              start,
  input  mdu_pkg::word_t    multiplicand,
  input  mdu_pkg::word_t    multiplier,
  input  logic              signd,
  input  logic              grant,
  output mdu_pkg::hilo_wr_t req,
  output logic              busy
);
  import mdu_pkg::*;

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_DONE
  } mul_state_e;

  mul_state_e state;
  logic [4:0] cnt;
  dword_t     prod;
  word_t      mcand;
  logic       neg_prod;
  word_t      abs_a;
  word_t      abs_b;
  dword_t     first_p;
  dword_t     src_p;
  word_t      src_mcand;
  logic [XLEN:0] sum;
  dword_t     step_p;
  dword_t     result;

  assign abs_a = (signd && multiplicand[XLEN-1]) ? -multiplicand : multiplicand;
  assign abs_b = (signd && multiplier[XLEN-1]) ? -multiplier : multiplier;

  // bit 0 against an empty accumulator needs no add
  assign first_p = {1'b0, (abs_b[0] ? abs_a : '0), abs_b[XLEN-1:1]};

  // adder then takes bit 1 in the same start cycle
  assign src_p     = start ? first_p : prod;
  assign src_mcand = start ? abs_a : mcand;

  // add into high half when low bit set, then shift right
  assign sum    = {1'b0, src_p[2*XLEN-1:XLEN]}
                + (src_p[0] ? {1'b0, src_mcand} : '0);
  assign step_p = {sum, src_p[XLEN-1:1]};

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      state <= MUL_IDLE;
      cnt   <= '0;
    end
    else if (start)
    begin
      state <= MUL_RUN;
      cnt   <= 5'd30;
    end
    else
    begin
      case (state)
        MUL_RUN:
        begin
          cnt <= cnt - 5'd1;
          if (cnt == 5'd1)
            state <= MUL_DONE;
        end
        MUL_DONE:
          if (grant)
            state <= MUL_IDLE;
        default: ;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      prod     <= step_p;
      mcand    <= abs_a;
      neg_prod <= signd && (multiplicand[XLEN-1] ^ multiplier[XLEN-1]);
    end
    else if (state == MUL_RUN)
      prod <= step_p;
  end

  assign result = neg_prod ? -prod : prod;

  assign req.we_hi = (state == MUL_DONE);
  assign req.we_lo = (state == MUL_DONE);
  assign req.hi    = result[2*XLEN-1:XLEN];
  assign req.lo    = result[XLEN-1:0];

  assign busy = start || (state != MUL_IDLE);

endmodule

/* src/hilo_arbiter.sv */
/*
  Fixed-priority HI/LO write arbiter: move-to, then divide, then multiply.
  Purely combinational; move-to writes are never held back.
  A losing engine keeps its request up and is granted in a later cycle.
*/
`timescale 1ns/100ps

module hilo_arbiter (
  input  mdu_pkg::hilo_wr_t mt_req,
  input  mdu_pkg::hilo_wr_t div_req,
  input  mdu_pkg::hilo_wr_t mul_req,
  output logic              div_grant,
  output logic              mul_grant,
  output mdu_pkg::hilo_wr_t wr
);

  logic mt_valid;
  logic div_valid;
  logic mul_valid;

  // any enable counts as a request
  assign mt_valid  = mt_req.we_hi || mt_req.we_lo;
  assign div_valid = div_req.we_hi || div_req.we_lo;
  assign mul_valid = mul_req.we_hi || mul_req.we_lo;

  always_comb
  begin
    div_grant = 1'b0;
    mul_grant = 1'b0;
    wr        = '0;
    if (mt_valid)
      wr = mt_req;
    else if (div_valid)
    begin
      wr        = div_req;
      div_grant = 1'b1;
    end
    else if (mul_valid)
    begin
      wr        = mul_req;
      mul_grant = 1'b1;
    end
  end

endmodule

/* src/hilo_regs.sv */
/*
  HI and LO architectural registers.
  Each half has its own write enable; both clear to zero on reset.
*/
`timescale 1ns/100ps

module hilo_regs (
  input  logic              clk,
  input  logic              nrst,
  input  mdu_pkg::hilo_wr_t wr,
  output mdu_pkg::word_t    hi,
  output mdu_pkg::word_t    lo
);

  // high word, remainder or product high
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
      hi <= '0;
    else if (wr.we_hi)
      hi <= wr.hi;
  end

  // low word, quotient or product low
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
      lo <= '0;
    else if (wr.we_lo)
      lo <= wr.lo;
  end

endmodule

/* src/mdu_top.sv */
/*
  Multiply/divide unit top level.
  One command per cycle; busy levels tell when a result is still pending.
  Divide results land on HI/LO 34 cycles after the strobe, multiplies 33,
  if nothing else is writing at the same time.
*/
`timescale 1ns/100ps

module mdu_top (
  input  logic               clk,
  input  logic               nrst,
  input  logic               cmd_valid,
  input  mdu_pkg::mdu_cmd_t  cmd,
  output mdu_pkg::mdu_busy_t busy,
  output logic               cmd_err,
  output mdu_pkg::word_t     hi,
  output mdu_pkg::word_t     lo
);
  import mdu_pkg::*;

  logic     div_start;
  logic     mul_start;
  word_t    opa;
  word_t    opb;
  logic     signd;
  hilo_wr_t mt_req;
  hilo_wr_t div_req;
  hilo_wr_t mul_req;
  hilo_wr_t wr;
  logic     div_grant;
  logic     mul_grant;
  logic     div_busy;
  logic     mul_busy;

  assign busy = '{mul: mul_busy, div: div_busy};

  mdu_issue issue_i (
    .clk       (clk),
    .nrst      (nrst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .div_start (div_start),
    .mul_start (mul_start),
    .opa       (opa),
    .opb       (opb),
    .signd     (signd),
    .mt_req    (mt_req),
    .cmd_err   (cmd_err)
  );

  long_idiv div_i (
    .clk      (clk),
    .nrst     (nrst),
    .start    (div_start),
    .dividend (opa),
    .divider  (opb),
    .signd    (signd),
    .grant    (div_grant),
    .req      (div_req),
    .busy     (div_busy)
  );

  long_imul mul_i (
    .clk          (clk),
    .nrst         (nrst),
    .start        (mul_start),
    .multiplicand (opa),
    .multiplier   (opb),
    .signd        (signd),
    .grant        (mul_grant),
    .req          (mul_req),
    .busy         (mul_busy)
  );

  hilo_arbiter arb_i (
    .mt_req    (mt_req),
    .div_req   (div_req),
    .mul_req   (mul_req),
    .div_grant (div_grant),
    .mul_grant (mul_grant),
    .wr        (wr)
  );

  hilo_regs regs_i (
    .clk  (clk),
    .nrst (nrst),
    .wr   (wr),
    .hi   (hi),
    .lo   (lo)
  );

endmodule

/* dv/mdu_tb.sv */
/*
  Directed testbench for the multiply/divide unit.
  Expected HI/LO values come from a 64-bit integer model kept here.
  Outputs are sampled on the falling edge; inputs change on the rising edge.
  The run stops at a fixed cycle limit sized from the test lengths.
*/
`timescale 1ns/100ps

module mdu_tb;
  import mdu_pkg::*;

  // about 50 engine operations of up to 40 cycles each
  localparam int NUM_OPS    = 50;
  localparam int OP_CYCLES  = 40;
  localparam int MAX_CYCLES = NUM_OPS * OP_CYCLES;

  localparam mdu_busy_t NONE_BUSY = '{mul: 1'b0, div: 1'b0};
  localparam mdu_busy_t DIV_BUSY  = '{mul: 1'b0, div: 1'b1};

  logic      clk = 1'b0;
  logic      nrst;
  logic      cmd_valid;
  mdu_cmd_t  cmd;
  mdu_busy_t busy;
  logic      cmd_err;
  word_t     hi;
  word_t     lo;

  integer seed;
  int     cycles = 0;
  int     checks = 0;
  int     errors = 0;
  int     err_mark = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  mdu_top dut_i (
    .clk       (clk),
    .nrst      (nrst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .cmd_err   (cmd_err),
    .hi        (hi),
    .lo        (lo)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // watchdog
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // remainder:quotient, zero operand gives all zeros
  function automatic dword_t div_model(input word_t a, input word_t b, input logic sgn);
    longint na;
    longint nb;
    longint q;
    longint r;
    if (a == 32'd0 || b == 32'd0)
      return '0;
    if (sgn)
    begin
      na = {{XLEN{a[XLEN-1]}}, a};
      nb = {{XLEN{b[XLEN-1]}}, b};
    end
    else
    begin
      na = {{XLEN{1'b0}}, a};
      nb = {{XLEN{1'b0}}, b};
    end
    // truncating division, remainder follows the dividend
    q = na / nb;
    r = na % nb;
    return {r[XLEN-1:0], q[XLEN-1:0]};
  endfunction

  // full 64-bit product, high:low
  function automatic dword_t mul_model(input word_t a, input word_t b, input logic sgn);
    longint na;
    longint nb;
    if (sgn)
    begin
      na = {{XLEN{a[XLEN-1]}}, a};
      nb = {{XLEN{b[XLEN-1]}}, b};
    end
    else
    begin
      na = {{XLEN{1'b0}}, a};
      nb = {{XLEN{1'b0}}, b};
    end
    return dword_t'(na * nb);
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_busy(input string name, input mdu_busy_t got, input mdu_busy_t want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
    end
  endtask

  // strobe held for one cycle unless another command follows
  task automatic send_cmd(input mdu_op_e op, input word_t a, input word_t b);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= '{op: op, a: a, b: b};
  endtask

  task automatic end_cmds();
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  // returns on the first falling edge with both engines idle
  task automatic wait_idle(input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while ((busy !== NONE_BUSY) && (n < limit))
    begin
      @(negedge clk);
      n++;
    end
    if (busy !== NONE_BUSY)
    begin
      errors++;
      $display("%s still busy %0d cycles after the strobe was taken", what, limit);
    end
  endtask

  // move-to lands one cycle after the command is taken
  task automatic write_move(input mdu_op_e op, input word_t val);
    send_cmd(op, val, 32'd0);
    end_cmds();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic run_div(input mdu_op_e op, input word_t a, input word_t b, input int limit);
    dword_t want;
    send_cmd(op, a, b);
    end_cmds();
    wait_idle(limit, "divide");
    want = div_model(a, b, op == DIV);
    check_word("hi", hi, want[2*XLEN-1:XLEN]);
    check_word("lo", lo, want[XLEN-1:0]);
  endtask

  // hi/lo must hold the old values for as long as busy.mul is up
  task automatic run_mul(input mdu_op_e op, input word_t a, input word_t b);
    dword_t want;
    word_t  old_hi;
    word_t  old_lo;
    int     n;
    old_hi = hi;
    old_lo = lo;
    n = 0;
    send_cmd(op, a, b);
    end_cmds();
    @(negedge clk);
    while ((busy.mul === 1'b1) && (n < OP_CYCLES))
    begin
      check_word("hi", hi, old_hi);
      check_word("lo", lo, old_lo);
      @(negedge clk);
      n++;
    end
    check_busy("busy", busy, NONE_BUSY);
    want = mul_model(a, b, op == MULT);
    check_word("hi", hi, want[2*XLEN-1:XLEN]);
    check_word("lo", lo, want[XLEN-1:0]);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == err_mark)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  task automatic test_reset();
    err_mark = errors;
    @(negedge clk);
    check_busy("busy", busy, NONE_BUSY);
    check_bit("cmd_err", cmd_err, 1'b0);
    check_word("hi", hi, 32'd0);
    check_word("lo", lo, 32'd0);
    report_test("reset");
  endtask

  task automatic test_divu();
    word_t a;
    word_t b;
    err_mark = errors;
    for (int i = 0; i < 20; i++)
    begin
      a = $random(seed);
      b = $random(seed);
      // spread divisor sizes
      b = b >> (i % 24);
      run_div(DIVU, a, b, OP_CYCLES);
    end
    run_div(DIVU, 32'hffff_ffff, 32'd1, OP_CYCLES);
    run_div(DIVU, 32'd1, 32'hffff_ffff, OP_CYCLES);
    report_test("divu");
  endtask

  task automatic test_div();
    word_t a;
    word_t b;
    err_mark = errors;
    // all four sign pairs
    run_div(DIV, 32'd1000, 32'd7, OP_CYCLES);
    run_div(DIV, -32'sd1000, 32'd7, OP_CYCLES);
    run_div(DIV, 32'd1000, -32'sd7, OP_CYCLES);
    run_div(DIV, -32'sd1000, -32'sd7, OP_CYCLES);
    for (int i = 0; i < 6; i++)
    begin
      a = $random(seed);
      b = $random(seed);
      b = b >> (i * 4);
      run_div(DIV, a, b, OP_CYCLES);
    end
    report_test("div");
  endtask

  // done within 4 cycles of the strobe, so a limit of 3 after acceptance
  task automatic test_zero();
    err_mark = errors;
    write_move(MTHI, 32'hdead_0001);
    write_move(MTLO, 32'hdead_0002);
    run_div(DIV, 32'h1234_5678, 32'd0, 3);
    write_move(MTHI, 32'hbeef_0003);
    write_move(MTLO, 32'hbeef_0004);
    run_div(DIVU, 32'd0, 32'h0000_0055, 3);
    report_test("zero");
  endtask

  task automatic test_mul();
    word_t   a;
    word_t   b;
    mdu_op_e op;
    err_mark = errors;
    run_mul(MULT, 32'h8000_0000, 32'h8000_0000);
    run_mul(MULT, 32'h8000_0000, 32'hffff_ffff);
    run_mul(MULT, 32'h7fff_ffff, 32'h8000_0000);
    run_mul(MULTU, 32'hffff_ffff, 32'hffff_ffff);
    run_mul(MULTU, 32'd0, 32'h1234_5678);
    for (int i = 0; i < 5; i++)
    begin
      a = $random(seed);
      b = $random(seed);
      // signed and unsigned in turn
      if (i % 2 == 0)
        op = MULT;
      else
        op = MULTU;
      run_mul(op, a, b);
    end
    report_test("mul");
  endtask

  task automatic test_contention();
    dword_t want;
    err_mark = errors;
    // both requests rise in the same cycle, divide wins first
    send_cmd(DIV, 32'h0765_4321, 32'd13);
    send_cmd(MULT, 32'hfedc_ba98, 32'h0001_2345);
    end_cmds();
    wait_idle(OP_CYCLES + 2, "divide and multiply");
    want = mul_model(32'hfedc_ba98, 32'h0001_2345, 1'b1);
    check_word("hi", hi, want[2*XLEN-1:XLEN]);
    check_word("lo", lo, want[XLEN-1:0]);
    // move-to overtakes a pending divide
    send_cmd(DIV, 32'd100, 32'd7);
    end_cmds();
    write_move(MTHI, 32'h0bad_cafe);
    check_word("hi", hi, 32'h0bad_cafe);
    check_busy("busy", busy, DIV_BUSY);
    wait_idle(OP_CYCLES, "divide");
    check_word("hi", hi, 32'd2);
    check_word("lo", lo, 32'd14);
    report_test("contention");
  endtask

  task automatic test_refused();
    dword_t want;
    word_t  old_hi;
    err_mark = errors;
    send_cmd(DIVU, 32'h00ff_0000, 32'd255);
    end_cmds();
    // second divide sampled while busy.div is up
    send_cmd(DIVU, 32'd9, 32'd3);
    end_cmds();
    @(negedge clk);
    check_bit("cmd_err", cmd_err, 1'b1);
    @(negedge clk);
    check_bit("cmd_err", cmd_err, 1'b0);
    check_busy("busy", busy, DIV_BUSY);
    wait_idle(OP_CYCLES, "divide");
    want = div_model(32'h00ff_0000, 32'd255, 1'b0);
    check_word("hi", hi, want[2*XLEN-1:XLEN]);
    check_word("lo", lo, want[XLEN-1:0]);
    // MTLO leaves hi alone
    old_hi = hi;
    write_move(MTLO, 32'h5a5a_a5a5);
    check_word("lo", lo, 32'h5a5a_a5a5);
    check_word("hi", hi, old_hi);
    report_test("refused");
  endtask

  initial
  begin
    seed = 32'hf98f_8f25;
    nrst      <= 1'b0;
    cmd_valid <= 1'b0;
    cmd       <= '{op: MULT, a: 32'd0, b: 32'd0};
    repeat (2) @(posedge clk);
    nrst <= 1'b1;

    test_reset();
    test_divu();
    test_div();
    test_zero();
    test_mul();
    test_contention();
    test_refused();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* mdu.f */
src/mdu_pkg.sv
src/mdu_issue.sv
src/long_idiv.sv
src/long_imul.sv
src/hilo_arbiter.sv
src/hilo_regs.sv
src/mdu_top.sv
dv/mdu_tb.sv

/* run.sh */
#!/bin/sh
# Build the MDU testbench with Verilator and run it.
# Exit status is 0 only when the run prints the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mdu_tb -Mdir obj_dir -f mdu.f \
  && ./obj_dir/Vmdu_tb | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }
